// ==== rtl/dequant_settings.svh ====
/* sizes shared by the dequantizer RTL and testbench.
   DQ_NUM_ROW must be a power of two and DQ_SCALE_DEPTH at least 2. */
`ifndef DEQUANT_SETTINGS_SVH
`define DEQUANT_SETTINGS_SVH

// lanes per row.
`define DQ_NUM_COL 4

// rows per matrix; the row index is log2 of this wide.
`define DQ_NUM_ROW 8

// signed accumulator width.
`define DQ_ACC_W 32

// scale rows buffered ahead of the accumulators.
`define DQ_SCALE_DEPTH 2

`endif

// ==== rtl/dequant_pkg.sv ====
/* FP32 and row types of the dequantizer.
   Only normal FP32 numbers are described; no denormal, infinity or NaN encodings. */
`default_nettype none

`include "dequant_settings.svh"

package dequant_pkg;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exp;     // biased by 127.
        logic [22:0] frac;
    } fp32_t;

    typedef union packed {
        logic [31:0] raw;
        fp32_t       f;
    } fp_word_u;

    // per-column scale with the mantissa stored without the hidden one.
    typedef struct packed {
        logic [7:0]  exp;
        logic [22:0] mant;
    } scale_t;

    typedef struct packed {
        logic [`DQ_NUM_COL-1:0][`DQ_ACC_W-1:0] acc;    // two's complement.
    } quant_row_t;

    typedef struct packed {
        scale_t [`DQ_NUM_COL-1:0] col;
    } scale_row_t;

    typedef struct packed {
        fp_word_u [`DQ_NUM_COL-1:0] col;
    } float_row_t;

    typedef logic [$clog2(`DQ_NUM_ROW)-1:0] row_idx_t;

endpackage

`default_nettype wire

// ==== rtl/dequant_lane.sv ====
/* combinational acc * scale to FP32 with a truncated fraction. Scale exponent must be 1..254
   and the result must stay normal; a zero accumulator gives the all-zero word. */
`default_nettype none

`include "dequant_settings.svh"

module dequant_lane
    import dequant_pkg::*;
(
    input  wire signed [`DQ_ACC_W-1:0] acc_i,
    input  wire scale_t                scale_i,
    output fp_word_u                   result_o
);

    localparam int ACC_W  = `DQ_ACC_W;
    localparam int POS_W  = $clog2(`DQ_ACC_W);
    localparam int PROD_W = `DQ_ACC_W + 24;

    logic [ACC_W-1:0]  mag;
    logic              is_zero;
    logic [POS_W-1:0]  top_pos;
    logic [POS_W-1:0]  shift;
    logic [ACC_W-1:0]  norm;
    logic [23:0]       scale_sig;
    logic [PROD_W-1:0] prod;
    logic              carry;
    logic [22:0]       frac;
    logic [7:0]        exp_sum;

    // most negative value maps to 2^(ACC_W-1) and still fits unsigned.
    assign mag     = acc_i[ACC_W-1] ? -acc_i : acc_i;
    assign is_zero = (mag == '0);

    // position of the highest set bit.
    always_comb begin
        top_pos = '0;
        for (int i = 0; i < ACC_W; i++) begin
            if (mag[i]) begin
                top_pos = POS_W'(i);
            end
        end
    end

    assign shift = POS_W'(ACC_W - 1) - top_pos;
    assign norm  = mag << shift;               // leading one now at the msb.

    assign scale_sig = {1'b1, scale_i.mant};   // restore hidden one.

    // 1.31 times 1.23 gives a product in [1, 4).
    assign prod  = norm * scale_sig;
    assign carry = prod[PROD_W-1];

    always_comb begin
        if (carry) begin
            frac = prod[PROD_W-2 -: 23];
        end else begin
            frac = prod[PROD_W-3 -: 23];
        end
    end

    // acc = 1.x * 2^top_pos, so the bias rides along with the scale exponent.
    assign exp_sum = scale_i.exp + 8'(top_pos) + 8'(carry);

    always_comb begin
        result_o.raw = '0;
        if (!is_zero) begin
            result_o.f.sign = acc_i[ACC_W-1];
            result_o.f.exp  = exp_sum;
            result_o.f.frac = frac;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/scale_fifo.sv ====
/* circular buffer of scale rows; push is refused when full even if a pop is underway.
   Data is valid one edge after the push. */
`default_nettype none

`include "dequant_settings.svh"

module scale_fifo
    import dequant_pkg::*;
(
    input  wire             clk,
    input  wire             rstnn,

    input  wire             push_valid_i,
    output logic            push_ready_o,
    input  wire scale_row_t push_row_i,

    output logic            pop_valid_o,
    input  wire             pop_ready_i,
    output scale_row_t      pop_row_o
);

    localparam int DEPTH = `DQ_SCALE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    scale_row_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push_ready_o = (count != CNT_W'(DEPTH));
    assign pop_valid_o  = (count != '0);
    assign do_push      = push_valid_i && push_ready_o;
    assign do_pop       = pop_ready_i && pop_valid_o;
    assign pop_row_o    = mem[rd_ptr];

    always_ff @(posedge clk or negedge rstnn) begin
        if (!rstnn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // none or both.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_row_i;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/dequant_row.sv ====
/* dequantizes one matrix of DQ_NUM_ROW rows per start pulse. The matrix ends when the row
   with index DQ_NUM_ROW-1 leaves, so rows must carry their own indices. */
`default_nettype none

`include "dequant_settings.svh"

module dequant_row
    import dequant_pkg::*;
(
    input  wire             clk,
    input  wire             rstnn,

    input  wire             start_i,
    output logic            busy_o,

    input  wire             quant_valid_i,
    output logic            quant_ready_o,
    input  wire quant_row_t quant_row_i,
    input  wire row_idx_t   row_index_i,

    input  wire             scale_valid_i,
    output logic            scale_ready_o,
    input  wire scale_row_t scale_row_i,

    output logic            float_valid_o,
    input  wire             float_ready_i,
    output float_row_t      float_row_o,
    output row_idx_t        row_index_o
);

    typedef enum logic {
        S_IDLE,
        S_BUSY
    } state_t;

    state_t          state;
    logic            s1_valid;
    quant_row_t      s1_quant;
    scale_row_t      s1_scale;
    row_idx_t        s1_index;
    logic            out_valid;
    float_row_t      out_row;
    row_idx_t        out_index;
    wire float_row_t lane_row;
    logic            out_open;
    logic            s1_open;
    logic            accept;
    logic            last_out;

    assign out_open = !out_valid || float_ready_i;   // empty or being read.
    assign s1_open  = !s1_valid || out_open;

    // a quant row and a scale row move together.
    assign quant_ready_o = busy_o && s1_open && scale_valid_i;
    assign scale_ready_o = busy_o && s1_open && quant_valid_i;
    assign accept        = quant_valid_i && quant_ready_o;

    assign last_out = out_valid && float_ready_i &&
                      (out_index == row_idx_t'(`DQ_NUM_ROW - 1));

    always_ff @(posedge clk or negedge rstnn) begin
        if (!rstnn) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start_i) begin
                        state <= S_BUSY;
                    end
                end
                default: begin
                    if (last_out) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    assign busy_o = (state == S_BUSY);

    always_ff @(posedge clk or negedge rstnn) begin
        if (!rstnn) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (accept) begin
                s1_valid <= 1'b1;
            end else if (out_open) begin
                s1_valid <= 1'b0;
            end
            if (out_open) begin
                out_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_quant <= quant_row_i;
            s1_scale <= scale_row_i;
            s1_index <= row_index_i;
        end
        if (out_open && s1_valid) begin
            out_row   <= lane_row;
            out_index <= s1_index;
        end
    end

    for (genvar c = 0; c < `DQ_NUM_COL; c++) begin : g_lane
        dequant_lane u_lane (
            .acc_i    (s1_quant.acc[c]),
            .scale_i  (s1_scale.col[c]),
            .result_o (lane_row.col[c])
        );
    end

    assign float_valid_o = out_valid;
    assign float_row_o   = out_row;
    assign row_index_o   = out_index;

endmodule

`default_nettype wire

// ==== rtl/dequant_top.sv ====
/* scale FIFO in front of the row dequantizer. Scale rows pair with quant rows strictly
   in arrival order. */
`default_nettype none

module dequant_top
    import dequant_pkg::*;
(
    input  wire             clk,
    input  wire             rstnn,

    input  wire             start_i,
    output logic            busy_o,

    input  wire             quant_valid_i,
    output logic            quant_ready_o,
    input  wire quant_row_t quant_row_i,
    input  wire row_idx_t   row_index_i,

    input  wire             scale_valid_i,
    output logic            scale_ready_o,
    input  wire scale_row_t scale_row_i,

    output logic            float_valid_o,
    input  wire             float_ready_i,
    output float_row_t      float_row_o,
    output row_idx_t        row_index_o
);

    logic       fifo_valid;
    logic       fifo_ready;
    scale_row_t fifo_row;

    scale_fifo u_scale_fifo (
        .clk          (clk),
        .rstnn        (rstnn),
        .push_valid_i (scale_valid_i),
        .push_ready_o (scale_ready_o),
        .push_row_i   (scale_row_i),
        .pop_valid_o  (fifo_valid),
        .pop_ready_i  (fifo_ready),
        .pop_row_o    (fifo_row)
    );

    dequant_row u_dequant_row (
        .clk           (clk),
        .rstnn         (rstnn),
        .start_i       (start_i),
        .busy_o        (busy_o),
        .quant_valid_i (quant_valid_i),
        .quant_ready_o (quant_ready_o),
        .quant_row_i   (quant_row_i),
        .row_index_i   (row_index_i),
        .scale_valid_i (fifo_valid),
        .scale_ready_o (fifo_ready),
        .scale_row_i   (fifo_row),
        .float_valid_o (float_valid_o),
        .float_ready_i (float_ready_i),
        .float_row_o   (float_row_o),
        .row_index_o   (row_index_o)
    );

endmodule

`default_nettype wire

// ==== verification/dequant_model.svh ====
/* reference FP32 conversion and typed compares; included inside the testbench module,
   which imports dequant_pkg and provides stop_on_error. */
`ifndef DEQUANT_MODEL_SVH
`define DEQUANT_MODEL_SVH

// full product first, then normalize it, so no bits are lost before truncation.
function automatic fp_word_u model_word(input logic [`DQ_ACC_W-1:0] acc, input scale_t sc);
    logic [63:0] mag;
    logic [63:0] prod;
    logic [63:0] aligned;
    int          top;
    fp_word_u    word;
    word.raw = '0;
    mag      = 64'(acc);
    if (acc[`DQ_ACC_W-1]) begin
        mag = (64'd1 << `DQ_ACC_W) - mag;   // two's complement magnitude.
    end
    if (mag == '0) begin
        return word;
    end
    prod = mag * {40'd0, 1'b1, sc.mant};
    top  = 0;
    for (int i = 0; i < 64; i++) begin
        if (prod[i]) begin
            top = i;
        end
    end
    aligned        = prod << (63 - top);
    word.f.sign    = acc[`DQ_ACC_W-1];
    word.f.exp     = 8'(int'(sc.exp) + top - 23);   // mantissa scaled by 2^23.
    word.f.frac    = aligned[62:40];
    return word;
endfunction

function automatic float_row_t model_row(input quant_row_t q, input scale_row_t s);
    float_row_t row;
    for (int c = 0; c < `DQ_NUM_COL; c++) begin
        row.col[c] = model_word(q.acc[c], s.col[c]);
    end
    return row;
endfunction

task automatic compare_row(input float_row_t got, input float_row_t exp, input string name);
    if (got !== exp) begin
        stop_on_error($sformatf("Mismatch at %0d ns: %s got %h expected %h",
                                $time, name, got, exp));
    end
endtask

task automatic compare_index(input row_idx_t got, input row_idx_t exp, input string name);
    if (got !== exp) begin
        stop_on_error($sformatf("Mismatch at %0d ns: %s got %0d expected %0d",
                                $time, name, got, exp));
    end
endtask

task automatic compare_flag(input logic got, input logic exp, input string name);
    if (got !== exp) begin
        stop_on_error($sformatf("Mismatch at %0d ns: %s got %b expected %b",
                                $time, name, got, exp));
    end
endtask

`endif

// ==== verification/dequant_tb.sv ====
/* directed tests of dequant_top; expected rows come from the reference model.
   Scale exponents stay in 100..200 so every result is a normal number. */
`default_nettype none

`include "dequant_settings.svh"

module dequant_tb
    import dequant_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ROW    = `DQ_NUM_ROW;
    localparam int NUM_COL    = `DQ_NUM_COL;
    localparam int ACC_W      = `DQ_ACC_W;
    localparam int CLK_PERIOD = 10;
    localparam int TOTAL_ROWS = 6 * NUM_ROW + 1;   // six matrices and the idle offer.

    logic       clk = 1'b0;
    logic       rstnn;
    logic       start_i;
    logic       busy_o;
    logic       quant_valid_i;
    logic       quant_ready_o;
    quant_row_t quant_row_i;
    row_idx_t   row_index_i;
    logic       scale_valid_i;
    logic       scale_ready_o;
    scale_row_t scale_row_i;
    logic       float_valid_o;
    logic       float_ready_i;
    float_row_t float_row_o;
    row_idx_t   row_index_o;

    quant_row_t q_rows [NUM_ROW];
    scale_row_t s_rows [NUM_ROW];
    float_row_t e_rows [NUM_ROW];
    int         accepted;

    dequant_top dut (
        .clk           (clk),
        .rstnn         (rstnn),
        .start_i       (start_i),
        .busy_o        (busy_o),
        .quant_valid_i (quant_valid_i),
        .quant_ready_o (quant_ready_o),
        .quant_row_i   (quant_row_i),
        .row_index_i   (row_index_i),
        .scale_valid_i (scale_valid_i),
        .scale_ready_o (scale_ready_o),
        .scale_row_i   (scale_row_i),
        .float_valid_o (float_valid_o),
        .float_ready_i (float_ready_i),
        .float_row_o   (float_row_o),
        .row_index_o   (row_index_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    `include "dequant_model.svh"

    initial begin
        #(200 * TOTAL_ROWS * CLK_PERIOD);
        stop_on_error("watchdog expired before the tests finished");
    end

    task automatic reset_dut();
        rstnn         <= 1'b0;
        start_i       <= 1'b0;
        quant_valid_i <= 1'b0;
        quant_row_i   <= '0;
        row_index_i   <= '0;
        scale_valid_i <= 1'b0;
        scale_row_i   <= '0;
        float_ready_i <= 1'b0;
        repeat (16) @(posedge clk);
        rstnn <= 1'b1;
    endtask

    function automatic logic [ACC_W-1:0] random_acc();
        case ($urandom_range(7, 0))
            0:       return '0;
            1:       return {1'b1, {(ACC_W - 1){1'b0}}};
            2:       return {1'b0, {(ACC_W - 1){1'b1}}};
            3:       return '1;                             // minus one.
            4:       return ACC_W'($urandom_range(255, 0));
            default: return ACC_W'($urandom);
        endcase
    endfunction

    task automatic make_matrix();
        for (int r = 0; r < NUM_ROW; r++) begin
            for (int c = 0; c < NUM_COL; c++) begin
                q_rows[r].acc[c]      = random_acc();
                s_rows[r].col[c].exp  = 8'($urandom_range(200, 100));
                s_rows[r].col[c].mant = 23'($urandom);
            end
            e_rows[r] = model_row(q_rows[r], s_rows[r]);
        end
    endtask

    task automatic start_matrix();
        @(posedge clk);
        start_i <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        @(negedge clk);
        compare_flag(busy_o, 1'b1, "busy_o");
    endtask

    // returns on the edge that moves the row.
    task automatic send_scale(input scale_row_t row);
        @(posedge clk);
        scale_valid_i <= 1'b1;
        scale_row_i   <= row;
        @(negedge clk);
        while (!scale_ready_o) @(negedge clk);
        @(posedge clk);
        scale_valid_i <= 1'b0;
    endtask

    task automatic send_quant(input quant_row_t row, input row_idx_t index);
        @(posedge clk);
        quant_valid_i <= 1'b1;
        quant_row_i   <= row;
        row_index_i   <= index;
        @(negedge clk);
        while (!quant_ready_o) @(negedge clk);
        @(posedge clk);
        quant_valid_i <= 1'b0;
        accepted++;
    endtask

    // float_ready_i must be high; busy must drop with the last row.
    task automatic check_output(input int r);
        compare_row(float_row_o, e_rows[r], "float_row_o");
        compare_index(row_index_o, row_idx_t'(r), "row_index_o");
        if (r == NUM_ROW - 1) begin
            compare_flag(busy_o, 1'b1, "busy_o");
            @(negedge clk);
            compare_flag(busy_o, 1'b0, "busy_o");
        end
    endtask

    task automatic receive_row(input int r);
        @(negedge clk);
        while (!float_valid_o) @(negedge clk);
        check_output(r);
    endtask

    task automatic stream_matrix(input int first_scale);
        @(posedge clk);
        float_ready_i <= 1'b1;
        fork
            begin
                for (int r = first_scale; r < NUM_ROW; r++) send_scale(s_rows[r]);
            end
            begin
                for (int r = 0; r < NUM_ROW; r++) send_quant(q_rows[r], row_idx_t'(r));
            end
            begin
                for (int r = 0; r < NUM_ROW; r++) receive_row(r);
            end
        join
    endtask

    task automatic test_idle();
        make_matrix();
        @(negedge clk);
        compare_flag(busy_o, 1'b0, "busy_o");
        compare_flag(quant_ready_o, 1'b0, "quant_ready_o");
        compare_flag(float_valid_o, 1'b0, "float_valid_o");
        compare_flag(scale_ready_o, 1'b1, "scale_ready_o");
        @(posedge clk);
        quant_valid_i <= 1'b1;
        quant_row_i   <= q_rows[0];
        scale_valid_i <= 1'b1;
        scale_row_i   <= s_rows[0];
        repeat (8) begin
            @(negedge clk);
            compare_flag(quant_ready_o, 1'b0, "quant_ready_o");
            compare_flag(float_valid_o, 1'b0, "float_valid_o");
        end
        @(posedge clk);
        reset_dut();   // drops the scale rows taken while idle.
    endtask

    task automatic test_full_matrix();
        make_matrix();
        q_rows[0].acc[0] = '0;
        q_rows[0].acc[1] = {1'b1, {(ACC_W - 1){1'b0}}};
        q_rows[0].acc[2] = {1'b0, {(ACC_W - 1){1'b1}}};
        q_rows[0].acc[3] = '1;
        e_rows[0]        = model_row(q_rows[0], s_rows[0]);
        start_matrix();
        stream_matrix(0);
    endtask

    task automatic test_latency();
        make_matrix();
        start_matrix();
        @(posedge clk);
        float_ready_i <= 1'b1;
        for (int r = 0; r < NUM_ROW; r++) begin
            send_scale(s_rows[r]);
            @(posedge clk);
            send_quant(q_rows[r], row_idx_t'(r));
            @(negedge clk);
            compare_flag(float_valid_o, 1'b0, "float_valid_o");
            @(negedge clk);
            compare_flag(float_valid_o, 1'b1, "float_valid_o");
            check_output(r);
        end
    endtask

    task automatic test_back_pressure();
        make_matrix();
        start_matrix();
        @(posedge clk);
        float_ready_i <= 1'b0;
        accepted = 0;
        fork
            begin
                for (int r = 0; r < NUM_ROW; r++) send_scale(s_rows[r]);
            end
            begin
                for (int r = 0; r < NUM_ROW; r++) send_quant(q_rows[r], row_idx_t'(r));
            end
            begin
                while (accepted < 2) @(negedge clk);
                repeat (6) begin
                    @(negedge clk);
                    compare_flag(quant_ready_o, 1'b0, "quant_ready_o");
                    compare_flag(float_valid_o, 1'b1, "float_valid_o");
                    compare_row(float_row_o, e_rows[0], "float_row_o");
                    compare_index(row_index_o, '0, "row_index_o");
                end
                @(posedge clk);
                float_ready_i <= 1'b1;
                for (int r = 0; r < NUM_ROW; r++) receive_row(r);
            end
        join
    endtask

    task automatic test_scale_ahead();
        int pushed;
        make_matrix();
        start_matrix();
        for (pushed = 0; pushed < NUM_ROW; pushed++) begin
            @(negedge clk);
            if (!scale_ready_o) begin
                break;
            end
            send_scale(s_rows[pushed]);
        end
        if (pushed != `DQ_SCALE_DEPTH) begin
            stop_on_error($sformatf("scale FIFO took %0d rows before it filled", pushed));
        end
        repeat (10) @(posedge clk);
        stream_matrix(pushed);
    endtask

    task automatic test_matrix_end();
        make_matrix();
        start_matrix();
        stream_matrix(0);
        make_matrix();
        send_scale(s_rows[0]);   // buffered while idle.
        repeat (4) begin
            @(negedge clk);
            compare_flag(busy_o, 1'b0, "busy_o");
            compare_flag(quant_ready_o, 1'b0, "quant_ready_o");
        end
        start_matrix();
        stream_matrix(1);
    endtask

    initial begin
        void'($urandom(2));
        reset_dut();
        test_idle();
        test_full_matrix();
        test_latency();
        test_back_pressure();
        test_scale_ahead();
        test_matrix_end();
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+rtl
+incdir+verification
rtl/dequant_pkg.sv
rtl/dequant_lane.sv
rtl/scale_fifo.sv
rtl/dequant_row.sv
rtl/dequant_top.sv
verification/dequant_tb.sv

// ==== Bender.yml ====
package:
  name: dequant

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/dequant_pkg.sv
      - rtl/dequant_lane.sv
      - rtl/scale_fifo.sv
      - rtl/dequant_row.sv
      - rtl/dequant_top.sv
  - target: test
    include_dirs:
      - rtl
      - verification
    files:
      - verification/dequant_tb.sv
